// File: files.f
source/floo_pkg.sv
source/floo_fifo.sv
source/floo_output_arbiter.sv
source/floo_router.sv
source/floo_narrow_wide_router.sv
verification/floo_router_chk.sv
verification/tb_floo_narrow_wide_router.sv

// File: Makefile
# Verilator build and run of the narrow/wide mesh router testbench

TOP := tb_floo_narrow_wide_router

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

// File: verification/tb_floo_narrow_wide_router.sv
/*
 * Testbench of the narrow/wide mesh router node
 * Random traffic and back-pressure on all three networks,
 * XY routing scoreboard, compare tasks and watchdog
 */

`timescale 1ns/10ps

module tb_floo_narrow_wide_router
  import floo_pkg::*;
();

  localparam int unsigned NumNets        = 3;
  localparam int unsigned FlitsPerPort   = 40;
  localparam int unsigned TotalFlits     = NumNets * NumDirections * FlitsPerPort;
  localparam int unsigned WatchdogCycles = TotalFlits * 40;
  // Last quarter of each stream goes to one output
  localparam int unsigned HotStart       = (FlitsPerPort * 3) / 4;
  localparam node_id_t    HotDst         = 4'h3;
  localparam coord_t      OwnX           = 2'd1;
  localparam coord_t      OwnY           = 2'd2;
  localparam node_id_t    OwnId          = {OwnY, OwnX};

  logic     clk;
  logic     reset;
  node_id_t xy_id;

  // Network index 0 request, 1 response, 2 wide
  logic [NumDirections-1:0] valid_in  [NumNets];
  logic [NumDirections-1:0] ready_out [NumNets];
  logic [NumDirections-1:0] valid_out [NumNets];
  logic [NumDirections-1:0] ready_in  [NumNets];
  wide_flit_t               data_in   [NumNets][NumDirections];
  wide_flit_t               data_out  [NumNets][NumDirections];

  narrow_flit_t [NumDirections-1:0] req_data_i;
  narrow_flit_t [NumDirections-1:0] req_data_o;
  narrow_flit_t [NumDirections-1:0] rsp_data_i;
  narrow_flit_t [NumDirections-1:0] rsp_data_o;
  wide_flit_t   [NumDirections-1:0] wide_data_i;
  wide_flit_t   [NumDirections-1:0] wide_data_o;

  // Expected flits per network, output and source port
  wide_flit_t  exp_q [NumNets*NumDirections*NumDirections][$];
  int unsigned created [NumNets][NumDirections];
  int unsigned sent_total;
  int unsigned recv_total;

  for (genvar p = 0; p < NumDirections; p++) begin : gen_map
    assign req_data_i[p]  = narrow_flit_t'(data_in[0][p]);
    assign rsp_data_i[p]  = narrow_flit_t'(data_in[1][p]);
    assign wide_data_i[p] = data_in[2][p];
    assign data_out[0][p] = wide_flit_t'(req_data_o[p]);
    assign data_out[1][p] = wide_flit_t'(rsp_data_o[p]);
    assign data_out[2][p] = wide_data_o[p];
  end

  floo_narrow_wide_router #(
    .FifoDepth ( 2 )
  ) u_floo_narrow_wide_router (
    .clk_i        ( clk          ),
    .reset_i      ( reset        ),
    .xy_id_i      ( xy_id        ),
    .req_valid_i  ( valid_in[0]  ),
    .req_ready_o  ( ready_out[0] ),
    .req_data_i   ( req_data_i   ),
    .req_valid_o  ( valid_out[0] ),
    .req_ready_i  ( ready_in[0]  ),
    .req_data_o   ( req_data_o   ),
    .rsp_valid_i  ( valid_in[1]  ),
    .rsp_ready_o  ( ready_out[1] ),
    .rsp_data_i   ( rsp_data_i   ),
    .rsp_valid_o  ( valid_out[1] ),
    .rsp_ready_i  ( ready_in[1]  ),
    .rsp_data_o   ( rsp_data_o   ),
    .wide_valid_i ( valid_in[2]  ),
    .wide_ready_o ( ready_out[2] ),
    .wide_data_i  ( wide_data_i  ),
    .wide_valid_o ( valid_out[2] ),
    .wide_ready_i ( ready_in[2]  ),
    .wide_data_o  ( wide_data_o  )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic compare_narrow(narrow_flit_t got, narrow_flit_t exp, string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_wide(wide_flit_t got, wide_flit_t exp, string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_port(route_dir_e got, route_dir_e exp, string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %s, expected %s", $time, what, got.name(),
               exp.name());
      abort_run();
    end
  endtask

  task automatic compare_flags(logic [NumDirections-1:0] got, logic [NumDirections-1:0] exp,
                               string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // XY rule for a node at x 1, y 2
  function automatic route_dir_e model_dir(node_id_t dst);
    coord_t dx;
    coord_t dy;
    dx = dst[1:0];
    dy = dst[3:2];
    if (dx > OwnX) return East;
    if (dx < OwnX) return West;
    if (dy > OwnY) return North;
    if (dy < OwnY) return South;
    return Eject;
  endfunction

  function automatic int unsigned queue_index(int unsigned net, int unsigned dir,
                                              int unsigned src);
    return (net * NumDirections + dir) * NumDirections + src;
  endfunction

  // Payload carries the network in bits 8:7 and the sequence number in bits 24:9
  function automatic wide_flit_t make_flit(int unsigned net, int unsigned port,
                                           int unsigned seq);
    wide_flit_t flit;
    node_id_t   dst;
    flit = {$urandom(), $urandom()};
    if (seq >= HotStart) begin
      dst = HotDst;
    end else begin
      dst = node_id_t'($urandom_range(15, 0));
    end
    flit[DstLsb +: $bits(node_id_t)] = dst;
    flit[SrcLsb +: SrcWidth]         = SrcWidth'(port);
    flit[8:7]                        = 2'(net);
    flit[24:9]                       = 16'(seq);
    return flit;
  endfunction

  task automatic check_output(int unsigned net, int unsigned port, wide_flit_t got);
    int unsigned src;
    int unsigned idx;
    wide_flit_t  exp;
    src = 32'(got[SrcLsb +: SrcWidth]);
    compare_port(route_dir_e'(port), model_dir(node_id_t'(got[DstLsb +: $bits(node_id_t)])),
                 "output port of flit");
    idx = queue_index(net, port, src);
    if (src >= NumDirections || exp_q[idx].size() == 0) begin
      $display("Unexpected flit %h on network %0d output %0d at %0t", got, net, port, $time);
      abort_run();
    end
    exp = exp_q[idx].pop_front();
    if (net < 2) begin
      compare_narrow(narrow_flit_t'(got), narrow_flit_t'(exp), "narrow flit content");
    end else begin
      compare_wide(got, exp, "wide flit content");
    end
    recv_total += 1;
  endtask

  // Scoreboard update, source generators and sink back-pressure
  always @(posedge clk) begin
    wide_flit_t flit;
    logic       accepted;
    if (!reset) begin
      for (int unsigned n = 0; n < NumNets; n++) begin
        for (int unsigned p = 0; p < NumDirections; p++) begin
          flit     = data_in[n][p];
          accepted = valid_in[n][p] && ready_out[n][p];
          if (accepted) begin
            exp_q[queue_index(n, 32'(model_dir(node_id_t'(flit[DstLsb +: $bits(node_id_t)]))),
                              p)].push_back(flit);
            sent_total += 1;
          end
          if (valid_out[n][p] && ready_in[n][p]) begin
            check_output(n, p, data_out[n][p]);
          end
          if (!valid_in[n][p] || accepted) begin
            if (created[n][p] < FlitsPerPort && $urandom_range(2, 0) != 0) begin
              data_in[n][p]  <= make_flit(n, p, created[n][p]);
              valid_in[n][p] <= 1'b1;
              created[n][p] += 1;
            end else begin
              valid_in[n][p] <= 1'b0;
            end
          end
          ready_in[n][p] <= ($urandom_range(3, 0) != 0);
        end
      end
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: only %0d of %0d flits delivered", recv_total, TotalFlits);
    abort_run();
  end

  initial begin
    int unsigned leftover;
    void'($urandom(2));
    reset      = 1'b1;
    xy_id      = OwnId;
    sent_total = 0;
    recv_total = 0;
    for (int unsigned n = 0; n < NumNets; n++) begin
      valid_in[n] = '0;
      ready_in[n] = '1;
      for (int unsigned p = 0; p < NumDirections; p++) begin
        data_in[n][p] = '0;
        created[n][p] = 0;
      end
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    for (int unsigned n = 0; n < NumNets; n++) begin
      compare_flags(valid_out[n], '0, "valid outputs after reset");
      compare_flags(ready_out[n], '1, "ready outputs after reset");
    end
    // Every flit is in the DUT, which is empty once no output is valid
    wait (sent_total == TotalFlits);
    @(posedge clk);
    while ((valid_out[0] | valid_out[1] | valid_out[2]) != '0) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);
    for (int unsigned n = 0; n < NumNets; n++) begin
      compare_flags(valid_out[n], '0, "valid outputs after drain");
    end
    leftover = 0;
    for (int unsigned i = 0; i < NumNets * NumDirections * NumDirections; i++) begin
      leftover += 32'(exp_q[i].size());
    end
    if (leftover == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("%0d expected flits never arrived", leftover);
      abort_run();
    end
  end

endmodule

// File: verification/floo_router_chk.sv
/*
 * Assertions on the outputs of one router core
 * Stall stability, idle outputs after reset,
 * grants only to requesting inputs
 */

`timescale 1ns/10ps

module floo_router_chk
  import floo_pkg::*;
#(
  parameter int unsigned FlitWidth = 32
) (
  input logic                                         clk_i,
  input logic                                         reset_i,
  input logic [NumDirections-1:0]                     valid_i,
  input logic [NumDirections-1:0]                     ready_i,
  input logic [NumDirections-1:0][FlitWidth-1:0]      data_i,
  input logic [NumDirections-1:0][NumDirections-1:0]  req_i,
  input logic [NumDirections-1:0][NumDirections-1:0]  gnt_i
);

  // Outputs are idle in the cycle after a reset edge
  assert property (@(posedge clk_i) reset_i |=> (valid_i == '0))
    else $error("router output valid high in the cycle after reset");

  for (genvar o = 0; o < NumDirections; o++) begin : gen_port
    // A stalled flit is neither withdrawn nor replaced
    assert property (@(posedge clk_i) disable iff (reset_i)
      (valid_i[o] && !ready_i[o]) |=> (valid_i[o] && $stable(data_i[o])))
      else $error("output %0d changed while stalled", o);

    // Exactly one requesting input holds the grant while any input requests
    assert property (@(posedge clk_i) disable iff (reset_i)
      ((gnt_i[o] & ~req_i[o]) == '0) && (!(|req_i[o]) || $onehot(gnt_i[o])))
      else $error("output %0d arbiter grant is not a single requesting input", o);
  end

endmodule

bind floo_router floo_router_chk #(
  .FlitWidth ( FlitWidth )
) u_router_chk (
  .clk_i   ( clk_i   ),
  .reset_i ( reset_i ),
  .valid_i ( valid_o ),
  .ready_i ( ready_i ),
  .data_i  ( data_o  ),
  .req_i   ( out_req ),
  .gnt_i   ( out_gnt )
);

// File: source/floo_narrow_wide_router.sv
/*
 * Mesh node with three physical networks
 * Narrow request and response router cores and one wide router core,
 * all sharing the node coordinate
 */

`timescale 1ns/10ps

module floo_narrow_wide_router
  import floo_pkg::*;
#(
  parameter int unsigned FifoDepth = 2
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  node_id_t                         xy_id_i,

  // Request network
  input  logic         [NumDirections-1:0] req_valid_i,
  output logic         [NumDirections-1:0] req_ready_o,
  input  narrow_flit_t [NumDirections-1:0] req_data_i,
  output logic         [NumDirections-1:0] req_valid_o,
  input  logic         [NumDirections-1:0] req_ready_i,
  output narrow_flit_t [NumDirections-1:0] req_data_o,

  // Response network
  input  logic         [NumDirections-1:0] rsp_valid_i,
  output logic         [NumDirections-1:0] rsp_ready_o,
  input  narrow_flit_t [NumDirections-1:0] rsp_data_i,
  output logic         [NumDirections-1:0] rsp_valid_o,
  input  logic         [NumDirections-1:0] rsp_ready_i,
  output narrow_flit_t [NumDirections-1:0] rsp_data_o,

  // Wide network
  input  logic         [NumDirections-1:0] wide_valid_i,
  output logic         [NumDirections-1:0] wide_ready_o,
  input  wide_flit_t   [NumDirections-1:0] wide_data_i,
  output logic         [NumDirections-1:0] wide_valid_o,
  input  logic         [NumDirections-1:0] wide_ready_i,
  output wide_flit_t   [NumDirections-1:0] wide_data_o
);

  floo_router #(
    .FlitWidth ( $bits(narrow_flit_t) ),
    .FifoDepth ( FifoDepth            )
  ) u_req_router (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .xy_id_i ( xy_id_i     ),
    .valid_i ( req_valid_i ),
    .ready_o ( req_ready_o ),
    .data_i  ( req_data_i  ),
    .valid_o ( req_valid_o ),
    .ready_i ( req_ready_i ),
    .data_o  ( req_data_o  )
  );

  floo_router #(
    .FlitWidth ( $bits(narrow_flit_t) ),
    .FifoDepth ( FifoDepth            )
  ) u_rsp_router (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .xy_id_i ( xy_id_i     ),
    .valid_i ( rsp_valid_i ),
    .ready_o ( rsp_ready_o ),
    .data_i  ( rsp_data_i  ),
    .valid_o ( rsp_valid_o ),
    .ready_i ( rsp_ready_i ),
    .data_o  ( rsp_data_o  )
  );

  // Wide core uses the same routing on 64-bit flits
  floo_router #(
    .FlitWidth ( $bits(wide_flit_t) ),
    .FifoDepth ( FifoDepth          )
  ) u_wide_router (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .xy_id_i ( xy_id_i      ),
    .valid_i ( wide_valid_i ),
    .ready_o ( wide_ready_o ),
    .data_i  ( wide_data_i  ),
    .valid_o ( wide_valid_o ),
    .ready_i ( wide_ready_i ),
    .data_o  ( wide_data_o  )
  );

endmodule

// File: source/floo_router.sv
/*
 * Five-port mesh router core
 * Input FIFOs, XY route computation per input head,
 * one round-robin arbiter per output port
 */

`timescale 1ns/10ps

module floo_router
  import floo_pkg::*;
#(
  parameter int unsigned FlitWidth = 32,
  parameter int unsigned FifoDepth = 2
) (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  node_id_t                                 xy_id_i,

  input  logic [NumDirections-1:0]                 valid_i,
  output logic [NumDirections-1:0]                 ready_o,
  input  logic [NumDirections-1:0][FlitWidth-1:0]  data_i,

  output logic [NumDirections-1:0]                 valid_o,
  input  logic [NumDirections-1:0]                 ready_i,
  output logic [NumDirections-1:0][FlitWidth-1:0]  data_o
);

  // Dimension-ordered routing with x resolved before y
  function automatic logic [NumDirections-1:0] xy_route(node_id_t dst, node_id_t own);
    coord_t                   dst_x;
    coord_t                   dst_y;
    coord_t                   own_x;
    coord_t                   own_y;
    logic [NumDirections-1:0] sel;
    dst_x = coord_t'(dst[1:0]);
    dst_y = coord_t'(dst[3:2]);
    own_x = coord_t'(own[1:0]);
    own_y = coord_t'(own[3:2]);
    sel   = '0;
    if (dst_x > own_x) begin
      sel[East] = 1'b1;
    end else if (dst_x < own_x) begin
      sel[West] = 1'b1;
    end else if (dst_y > own_y) begin
      sel[North] = 1'b1;
    end else if (dst_y < own_y) begin
      sel[South] = 1'b1;
    end else begin
      sel[Eject] = 1'b1;
    end
    return sel;
  endfunction

  logic [NumDirections-1:0]                head_valid;
  logic [NumDirections-1:0]                head_ready;
  logic [NumDirections-1:0][FlitWidth-1:0] head_data;

  // route_sel[in][out] from the route computation
  logic [NumDirections-1:0][NumDirections-1:0] route_sel;
  // Request and grant matrices indexed [out][in]
  logic [NumDirections-1:0][NumDirections-1:0] out_req;
  logic [NumDirections-1:0][NumDirections-1:0] out_gnt;

  for (genvar i = 0; i < NumDirections; i++) begin : gen_input
    floo_fifo #(
      .FlitWidth ( FlitWidth ),
      .FifoDepth ( FifoDepth )
    ) u_in_fifo (
      .clk_i   ( clk_i         ),
      .reset_i ( reset_i       ),
      .valid_i ( valid_i[i]    ),
      .ready_o ( ready_o[i]    ),
      .data_i  ( data_i[i]     ),
      .valid_o ( head_valid[i] ),
      .ready_i ( head_ready[i] ),
      .data_o  ( head_data[i]  )
    );

    assign route_sel[i] = xy_route(node_id_t'(head_data[i][DstLsb +: $bits(node_id_t)]),
                                   xy_id_i);
  end

  for (genvar o = 0; o < NumDirections; o++) begin : gen_req
    for (genvar i = 0; i < NumDirections; i++) begin : gen_in
      assign out_req[o][i] = head_valid[i] & route_sel[i][o];
    end
  end

  // Pop a head once its output accepts it
  always_comb begin
    head_ready = '0;
    for (int unsigned i = 0; i < NumDirections; i++) begin
      for (int unsigned o = 0; o < NumDirections; o++) begin
        if (out_gnt[o][i] && ready_i[o]) begin
          head_ready[i] = 1'b1;
        end
      end
    end
  end

  for (genvar o = 0; o < NumDirections; o++) begin : gen_output
    floo_output_arbiter #(
      .FlitWidth ( FlitWidth )
    ) u_out_arb (
      .clk_i   ( clk_i      ),
      .reset_i ( reset_i    ),
      .req_i   ( out_req[o] ),
      .data_i  ( head_data  ),
      .gnt_o   ( out_gnt[o] ),
      .valid_o ( valid_o[o] ),
      .ready_i ( ready_i[o] ),
      .data_o  ( data_o[o]  )
    );
  end

endmodule

// File: source/floo_output_arbiter.sv
/*
 * Round-robin arbiter for one router output
 * Priority pointer, grant lock while the output stalls,
 * data multiplexer of the granted input
 */

`timescale 1ns/10ps

module floo_output_arbiter
  import floo_pkg::*;
#(
  parameter int unsigned FlitWidth = 32
) (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic [NumDirections-1:0]                 req_i,
  input  logic [NumDirections-1:0][FlitWidth-1:0]  data_i,
  output logic [NumDirections-1:0]                 gnt_o,
  output logic                                     valid_o,
  input  logic                                     ready_i,
  output logic [FlitWidth-1:0]                     data_o
);

  localparam int unsigned IdxWidth = $clog2(NumDirections);

  logic [IdxWidth-1:0] last_q;
  logic [IdxWidth-1:0] lock_idx_q;
  logic                lock_q;
  logic [IdxWidth-1:0] rr_idx;
  logic [IdxWidth-1:0] sel_idx;

  // First requester after the last granted input
  always_comb begin
    logic [IdxWidth-1:0] cand;
    logic                found;
    rr_idx = last_q;
    found  = 1'b0;
    for (int unsigned k = 1; k <= NumDirections; k++) begin
      cand = IdxWidth'((last_q + k) % NumDirections);
      if (!found && req_i[cand]) begin
        rr_idx = cand;
        found  = 1'b1;
      end
    end
  end

  // A stalled output keeps its grant until the flit is taken
  assign sel_idx = lock_q ? lock_idx_q : rr_idx;

  assign valid_o = |req_i;
  assign gnt_o   = valid_o ? (NumDirections'(1) << sel_idx) : '0;
  assign data_o  = data_i[sel_idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q     <= '0;
      lock_idx_q <= '0;
      lock_q     <= 1'b0;
    end else if (valid_o) begin
      if (ready_i) begin
        last_q <= sel_idx;
        lock_q <= 1'b0;
      end else begin
        lock_idx_q <= sel_idx;
        lock_q     <= 1'b1;
      end
    end
  end

endmodule

// File: source/floo_fifo.sv
/*
 * Input buffer of one router port
 * Circular buffer with registered head, no fall-through
 */

`timescale 1ns/10ps

module floo_fifo #(
  parameter int unsigned FlitWidth = 32,
  parameter int unsigned FifoDepth = 2
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  input  logic [FlitWidth-1:0] data_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output logic [FlitWidth-1:0] data_o
);

  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  logic [FlitWidth-1:0] mem_q [FifoDepth];
  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  logic [CntWidth-1:0]  count_q;
  logic                 push;
  logic                 pop;

  // Ready follows the fill level only
  assign ready_o = (count_q != CntWidth'(FifoDepth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: source/floo_pkg.sv
/*
 * Shared definitions of the mesh router
 * Coordinate and node id types, narrow and wide flit types,
 * port direction enum and flit field positions
 */

package floo_pkg;

  // Four mesh neighbours plus the local port
  localparam int unsigned NumDirections = 5;

  // Flit field positions are the same for narrow and wide flits
  localparam int unsigned DstLsb   = 0;
  localparam int unsigned SrcLsb   = 4;
  localparam int unsigned SrcWidth = 3;

  // One coordinate component of a 4 by 4 mesh
  typedef logic [1:0] coord_t;

  // Node coordinate, x in the low bits and y in the high bits
  typedef logic [3:0] node_id_t;

  // Flits of the request/response networks and of the wide network
  typedef logic [31:0] narrow_flit_t;
  typedef logic [63:0] wide_flit_t;

  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_dir_e;

endpackage
